// File: build.f
+incdir+verif
source/k16_arch_pkg.sv
source/k16_bus_pkg.sv
source/k16_alu.sv
source/k16_register_file.sv
source/k16_decoder.sv
source/k16_sequencer.sv
source/k16_cpu.sv
verif/k16_cpu_tb.sv

// File: source/k16_alu.sv
`timescale 1ns/1ps
`default_nettype none

module k16_alu (
  input  k16_arch_pkg::alu_in_t  alu_in,
  output k16_arch_pkg::alu_out_t alu_out
);
  import k16_arch_pkg::*;

  word_t       a;
  word_t       b;
  logic [16:0] sum;

  assign a = alu_in.operand1;
  assign b = alu_in.operand2;

  // Bit 16 is carry for additions and borrow for subtractions
  always_comb
  begin
    case (alu_in.alu_op)
      ALU_ADD:  sum = {1'b0, a} + {1'b0, b};
      ALU_ADC:  sum = {1'b0, a} + {1'b0, b} + {16'd0, alu_in.carry_in};
      ALU_SUB:  sum = {1'b0, a} - {1'b0, b};
      ALU_SBC:  sum = {1'b0, a} - {1'b0, b} - {16'd0, alu_in.carry_in};
      ALU_AND:  sum = {1'b0, a & b};
      ALU_OR:   sum = {1'b0, a | b};
      ALU_XOR:  sum = {1'b0, a ^ b};
      ALU_NOT:  sum = {1'b0, ~a};
      ALU_LDL:  sum = {1'b0, a[15:8], b[7:0]};
      ALU_LDH:  sum = {1'b0, b[7:0], a[7:0]};
      ALU_LDLZ: sum = {9'd0, b[7:0]};
      ALU_LDHZ: sum = {1'b0, b[7:0], 8'd0};
      default:  sum = '0;
    endcase
  end

  assign alu_out.result   = sum[15:0];
  assign alu_out.carry    = sum[16];
  assign alu_out.zero     = (sum[15:0] == 16'd0);
  assign alu_out.negative = sum[15];

endmodule

`default_nettype wire

// File: source/k16_arch_pkg.sv
`default_nettype none

package k16_arch_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_index_t;

  parameter reg_index_t SP_INDEX = 3'd6;
  parameter reg_index_t PC_INDEX = 3'd7;

  // Instruction groups in bits 15:13
  parameter logic [2:0] GRP_REG    = 3'b000;
  parameter logic [2:0] GRP_MISC   = 3'b001;
  parameter logic [2:0] GRP_BRANCH = 3'b010;
  parameter logic [2:0] GRP_IMM    = 3'b011;
  parameter logic [2:0] GRP_JUMP   = 3'b100;
  parameter logic [2:0] GRP_LOAD   = 3'b110;
  parameter logic [2:0] GRP_STORE  = 3'b111;

  // Low eight follow func4[2:0], byte loads follow 2'b10 and sub2
  typedef enum logic [3:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
    ALU_LDL, ALU_LDH, ALU_LDLZ, ALU_LDHZ
  } alu_op_t;

  typedef struct packed {
    word_t   operand1;
    word_t   operand2;
    alu_op_t alu_op;
    logic    carry_in;
  } alu_in_t;

  typedef struct packed {
    word_t result;
    logic  carry;
    logic  zero;
    logic  negative;
  } alu_out_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic zero;
  } flags_t;

  typedef struct packed {
    logic [2:0] group;
    reg_index_t dest;
    reg_index_t src1;
    reg_index_t src2;
    logic [3:0] func4;
  } reg_form_t;

  typedef struct packed {
    logic [2:0] group;
    reg_index_t dest;
    logic [1:0] sub2;
    logic [7:0] imm8;
  } imm_form_t;

  // dest doubles as the branch condition
  typedef struct packed {
    logic [2:0] group;
    reg_index_t dest;
    reg_index_t base;
    logic [6:0] off7;
  } mem_form_t;

  typedef struct packed {
    logic [2:0] group;
    reg_index_t base;
    logic [9:0] off10;
  } jump_form_t;

  typedef union packed {
    reg_form_t  reg_form;
    imm_form_t  imm_form;
    mem_form_t  mem_form;
    jump_form_t jump_form;
  } instr_t;

  typedef enum logic [3:0] {
    ACT_STORE, ACT_STORE_WITH_CARRY, ACT_COMPARE, ACT_JUMP, ACT_BRANCH,
    ACT_LOAD, ACT_STORE_MEM, ACT_SET_CARRY, ACT_HALT, ACT_NOP
  } action_t;

  typedef enum logic [1:0] {
    OP2_REG, OP2_IMM, OP2_ONE
  } operand2_sel_t;

  typedef struct packed {
    action_t       action;
    alu_op_t       alu_op;
    reg_index_t    dest;
    reg_index_t    src1;
    reg_index_t    src2;
    operand2_sel_t operand2_sel;
    word_t         imm;
    logic [2:0]    cond;
  } decode_t;

endpackage

`default_nettype wire

// File: source/k16_bus_pkg.sv
`default_nettype none

package k16_bus_pkg;

  typedef struct packed {
    k16_arch_pkg::word_t address;
    k16_arch_pkg::word_t wdata;
    logic                write;
  } mem_req_t;

  // Stack pointer starts just below the top of the 4K word memory
  parameter k16_arch_pkg::word_t DEFAULT_SP_RESET = 16'h0FFE;
  parameter k16_arch_pkg::word_t DEFAULT_PC_RESET = 16'h0000;

endpackage

`default_nettype wire

// File: source/k16_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module k16_cpu #(
  parameter k16_arch_pkg::word_t sp_reset = k16_bus_pkg::DEFAULT_SP_RESET,
  parameter k16_arch_pkg::word_t pc_reset = k16_bus_pkg::DEFAULT_PC_RESET
) (
  input  logic                  clk,
  input  logic                  reset,
  output k16_bus_pkg::mem_req_t mem,
  input  k16_arch_pkg::word_t   data_in,
  output logic                  halted
);
  import k16_arch_pkg::*;

  decode_t    decode;
  instr_t     instr;
  word_t      rd_a;
  word_t      rd_b;
  word_t      pc;
  reg_index_t rd_a_index;
  reg_index_t rd_b_index;
  logic       wr_en;
  reg_index_t wr_index;
  word_t      wr_data;
  alu_in_t    alu_in;
  alu_out_t   alu_out;

  k16_sequencer k16_sequencer_i (
    .clk        (clk),
    .reset      (reset),
    .decode     (decode),
    .instr      (instr),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .pc         (pc),
    .rd_a_index (rd_a_index),
    .rd_b_index (rd_b_index),
    .wr_en      (wr_en),
    .wr_index   (wr_index),
    .wr_data    (wr_data),
    .alu_in     (alu_in),
    .alu_out    (alu_out),
    .data_in    (data_in),
    .mem        (mem),
    .halted     (halted)
  );

  k16_decoder k16_decoder_i (
    .instr  (instr),
    .decode (decode)
  );

  k16_register_file #(
    .sp_reset (sp_reset),
    .pc_reset (pc_reset)
  ) k16_register_file_i (
    .clk        (clk),
    .reset      (reset),
    .rd_a_index (rd_a_index),
    .rd_b_index (rd_b_index),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .pc         (pc),
    .wr_en      (wr_en),
    .wr_index   (wr_index),
    .wr_data    (wr_data)
  );

  k16_alu k16_alu_i (
    .alu_in  (alu_in),
    .alu_out (alu_out)
  );

endmodule

`default_nettype wire

// File: source/k16_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module k16_decoder (
  input  k16_arch_pkg::instr_t  instr,
  output k16_arch_pkg::decode_t decode
);
  import k16_arch_pkg::*;

  word_t off7_ext;
  word_t off10_ext;

  assign off7_ext  = {{9{instr.mem_form.off7[6]}}, instr.mem_form.off7};
  assign off10_ext = {{6{instr.jump_form.off10[9]}}, instr.jump_form.off10};

  always_comb
  begin
    decode.action       = ACT_NOP;
    decode.alu_op       = ALU_ADD;
    decode.dest         = instr.reg_form.dest;
    decode.src1         = instr.reg_form.src1;
    decode.src2         = instr.reg_form.src2;
    decode.operand2_sel = OP2_REG;
    decode.imm          = '0;
    decode.cond         = instr.mem_form.dest;
    case (instr.reg_form.group)
      GRP_REG:
      begin
        casez (instr.reg_form.func4)
          4'b00??:
          begin
            decode.action = ACT_STORE_WITH_CARRY;
            decode.alu_op = alu_op_t'({1'b0, instr.reg_form.func4[2:0]});
          end
          4'b01??:
          begin
            decode.action = ACT_STORE;
            decode.alu_op = alu_op_t'({1'b0, instr.reg_form.func4[2:0]});
          end
          4'b1100:
          begin
            decode.action       = ACT_STORE;
            decode.operand2_sel = OP2_ONE;
          end
          4'b1110:
          begin
            decode.action = ACT_COMPARE;
            decode.alu_op = ALU_SUB;
          end
          4'b1111:
          begin
            decode.action       = ACT_STORE;
            decode.alu_op       = ALU_SUB;
            decode.operand2_sel = OP2_ONE;
          end
          default: decode.action = ACT_NOP;
        endcase
      end
      GRP_MISC:
      begin
        // Only CLC and SEC remain here, bit 0 is the new carry
        if (instr.reg_form.func4[3:1] == 3'b100)
        begin
          decode.action = ACT_SET_CARRY;
          decode.imm    = {15'd0, instr.reg_form.func4[0]};
        end
      end
      GRP_BRANCH:
      begin
        decode.action       = ACT_BRANCH;
        decode.src1         = instr.mem_form.base;
        decode.operand2_sel = OP2_IMM;
        decode.imm          = off7_ext;
      end
      GRP_IMM:
      begin
        decode.action       = ACT_STORE;
        decode.alu_op       = alu_op_t'({2'b10, instr.imm_form.sub2});
        decode.dest         = instr.imm_form.dest;
        decode.src1         = instr.imm_form.dest;
        decode.operand2_sel = OP2_IMM;
        decode.imm          = {8'd0, instr.imm_form.imm8};
      end
      GRP_JUMP:
      begin
        if ({instr.jump_form.base, instr.jump_form.off10} == 13'h1FFF)
        begin
          decode.action = ACT_HALT;
        end
        else
        begin
          decode.action       = ACT_JUMP;
          decode.src1         = instr.jump_form.base;
          decode.operand2_sel = OP2_IMM;
          decode.imm          = off10_ext;
        end
      end
      GRP_LOAD, GRP_STORE:
      begin
        decode.action       = (instr.mem_form.group == GRP_LOAD) ? ACT_LOAD : ACT_STORE_MEM;
        decode.dest         = instr.mem_form.dest;
        decode.src1         = instr.mem_form.base;
        decode.src2         = instr.mem_form.dest;
        decode.operand2_sel = OP2_IMM;
        decode.imm          = off7_ext;
      end
      default: decode.action = ACT_NOP;
    endcase
  end

endmodule

`default_nettype wire

// File: source/k16_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module k16_register_file #(
  parameter k16_arch_pkg::word_t sp_reset = k16_bus_pkg::DEFAULT_SP_RESET,
  parameter k16_arch_pkg::word_t pc_reset = k16_bus_pkg::DEFAULT_PC_RESET
) (
  input  logic                     clk,
  input  logic                     reset,
  input  k16_arch_pkg::reg_index_t rd_a_index,
  input  k16_arch_pkg::reg_index_t rd_b_index,
  output k16_arch_pkg::word_t      rd_a,
  output k16_arch_pkg::word_t      rd_b,
  output k16_arch_pkg::word_t      pc,
  input  logic                     wr_en,
  input  k16_arch_pkg::reg_index_t wr_index,
  input  k16_arch_pkg::word_t      wr_data
);
  import k16_arch_pkg::*;

  word_t regs [0:7];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < SP_INDEX; i++)
      begin
        regs[i] <= '0;
      end
      regs[SP_INDEX] <= sp_reset;
      regs[PC_INDEX] <= pc_reset;
    end
    else if (wr_en)
    begin
      regs[wr_index] <= wr_data;
    end
  end

  assign rd_a = regs[rd_a_index];
  assign rd_b = regs[rd_b_index];
  // Dedicated fetch port
  assign pc   = regs[PC_INDEX];

endmodule

`default_nettype wire

// File: source/k16_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module k16_sequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  k16_arch_pkg::decode_t    decode,
  output k16_arch_pkg::instr_t     instr,
  input  k16_arch_pkg::word_t      rd_a,
  input  k16_arch_pkg::word_t      rd_b,
  input  k16_arch_pkg::word_t      pc,
  output k16_arch_pkg::reg_index_t rd_a_index,
  output k16_arch_pkg::reg_index_t rd_b_index,
  output logic                     wr_en,
  output k16_arch_pkg::reg_index_t wr_index,
  output k16_arch_pkg::word_t      wr_data,
  output k16_arch_pkg::alu_in_t    alu_in,
  input  k16_arch_pkg::alu_out_t   alu_out,
  input  k16_arch_pkg::word_t      data_in,
  output k16_bus_pkg::mem_req_t    mem,
  output logic                     halted
);
  import k16_arch_pkg::*;

  typedef enum logic [2:0] {
    ST_FETCH, ST_WAIT, ST_DECODE, ST_EXECUTE,
    ST_LD_WAIT, ST_LD_READ, ST_STO_WAIT, ST_HALT
  } state_t;

  state_t state;
  flags_t flags;
  word_t  fetch_address;
  logic   branch_taken;
  logic   data_access;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_FETCH;
      flags <= '0;
    end
    else
    begin
      case (state)
        ST_FETCH:  state <= ST_WAIT;
        ST_WAIT:   state <= ST_DECODE;
        ST_DECODE: state <= ST_EXECUTE;
        ST_EXECUTE:
        begin
          state <= ST_FETCH;
          case (decode.action)
            ACT_STORE_WITH_CARRY, ACT_COMPARE:
            begin
              flags.carry    <= alu_out.carry;
              flags.zero     <= alu_out.zero;
              flags.negative <= alu_out.negative;
            end
            ACT_STORE:
            begin
              flags.zero     <= alu_out.zero;
              flags.negative <= alu_out.negative;
            end
            ACT_SET_CARRY: flags.carry <= decode.imm[0];
            ACT_LOAD:      state <= ST_LD_WAIT;
            ACT_STORE_MEM: state <= ST_STO_WAIT;
            ACT_HALT:      state <= ST_HALT;
            default:       state <= ST_FETCH;
          endcase
        end
        ST_LD_WAIT: state <= ST_LD_READ;
        ST_LD_READ:
        begin
          flags.zero     <= (data_in == 16'd0);
          flags.negative <= data_in[15];
          state          <= ST_FETCH;
        end
        ST_STO_WAIT: state <= ST_FETCH;
        ST_HALT:     state <= ST_HALT;
        default:     state <= ST_FETCH;
      endcase
    end
  end

  // Hold the fetch address while pc moves on in WAIT
  always_ff @(posedge clk)
  begin
    if (state == ST_FETCH)
    begin
      fetch_address <= pc;
    end
    if (state == ST_DECODE)
    begin
      instr <= data_in;
    end
  end

  // Overflow conditions are never taken
  always_comb
  begin
    case (decode.cond)
      3'd0:    branch_taken = flags.carry;
      3'd1:    branch_taken = !flags.carry;
      3'd2:    branch_taken = flags.zero;
      3'd3:    branch_taken = !flags.zero;
      3'd4:    branch_taken = flags.negative;
      3'd5:    branch_taken = !flags.negative;
      default: branch_taken = 1'b0;
    endcase
  end

  assign rd_a_index = decode.src1;
  assign rd_b_index = decode.src2;

  always_comb
  begin
    alu_in.alu_op   = decode.alu_op;
    alu_in.carry_in = flags.carry;
    alu_in.operand1 = rd_a;
    case (decode.operand2_sel)
      OP2_IMM: alu_in.operand2 = decode.imm;
      OP2_ONE: alu_in.operand2 = 16'd1;
      default: alu_in.operand2 = rd_b;
    endcase
    // Program counter increment
    if (state == ST_WAIT)
    begin
      alu_in.alu_op   = ALU_ADD;
      alu_in.operand1 = pc;
      alu_in.operand2 = 16'd1;
    end
  end

  always_comb
  begin
    wr_en    = 1'b0;
    wr_index = decode.dest;
    wr_data  = alu_out.result;
    case (state)
      ST_WAIT:
      begin
        wr_en    = 1'b1;
        wr_index = PC_INDEX;
      end
      ST_EXECUTE:
      begin
        case (decode.action)
          ACT_STORE, ACT_STORE_WITH_CARRY: wr_en = 1'b1;
          ACT_JUMP:
          begin
            wr_en    = 1'b1;
            wr_index = PC_INDEX;
          end
          ACT_BRANCH:
          begin
            wr_en    = branch_taken;
            wr_index = PC_INDEX;
          end
          default: wr_en = 1'b0;
        endcase
      end
      ST_LD_READ:
      begin
        wr_en   = 1'b1;
        wr_data = data_in;
      end
      default: wr_en = 1'b0;
    endcase
  end

  // Base plus offset stays on the ALU output for the whole load
  assign data_access = (state == ST_EXECUTE &&
                        (decode.action == ACT_LOAD || decode.action == ACT_STORE_MEM)) ||
                       state == ST_LD_WAIT || state == ST_LD_READ;

  assign mem.address = (state == ST_FETCH) ? pc :
                       (data_access ? alu_out.result : fetch_address);
  assign mem.wdata   = rd_b;
  assign mem.write   = (state == ST_EXECUTE) && (decode.action == ACT_STORE_MEM);

  assign halted = (state == ST_HALT);

endmodule

`default_nettype wire

// File: verif/k16_cpu_tests.svh
task automatic reset_state_test;
  emit(imm_instr(sub_ldhz, 5, 8'h01));
  emit(mem_instr(GRP_STORE, 6, 5, 0));
  emit(hlt_word);
  expect_slot(0, 16'h0ffe);
  run_program("reset_state");
  finish_test("reset_state");
endtask

task automatic alu_test;
  word_t a;
  word_t b;
  a = 16'h1234;
  b = 16'h0f0f;
  emit(imm_instr(sub_ldhz, 5, 8'h01));
  load_constant(1, a);
  load_constant(2, b);
  alu_case(fn_add, 1, 2, 0, a + b);
  alu_case(fn_sub, 1, 2, 1, a - b);
  alu_case(fn_and, 1, 2, 2, a & b);
  alu_case(fn_or, 1, 2, 3, a | b);
  alu_case(fn_xor, 1, 2, 4, a ^ b);
  alu_case(fn_not, 1, 2, 5, ~a);
  alu_case(fn_inc, 1, 2, 6, a + 16'd1);
  alu_case(fn_dec, 1, 2, 7, a - 16'd1);
  emit(mem_instr(GRP_STORE, 1, 5, 8));
  expect_slot(8, a);
  // LDL keeps the high byte
  emit(imm_instr(sub_ldl, 1, 8'h99));
  emit(mem_instr(GRP_STORE, 1, 5, 9));
  expect_slot(9, {a[15:8], 8'h99});
  emit(hlt_word);
  run_program("alu");
  finish_test("alu");
endtask

task automatic carry_branch_test;
  word_t ones;
  word_t one;
  ones = 16'hffff;
  one  = 16'h0001;
  emit(imm_instr(sub_ldhz, 5, 8'h01));
  load_constant(1, ones);
  emit(imm_instr(sub_ldlz, 2, one[7:0]));
  emit(sec_word);
  alu_case(fn_adc, 2, 0, 0, one + 16'd1);
  emit(clc_word);
  alu_case(fn_adc, 2, 0, 1, one);
  emit(sec_word);
  alu_case(fn_sbc, 2, 0, 2, one - 16'd1);
  emit(clc_word);
  alu_case(fn_sbc, 2, 0, 3, one);
  // Carry out of 0xffff + 1 feeds the next ADC
  alu_case(fn_add, 1, 2, 4, ones + one);
  alu_case(fn_adc, 0, 0, 5, 16'h0001);
  branch_case(6, 2, 2, one, one, cond_bzs);
  branch_case(7, 2, 2, one, one, cond_bzc);
  branch_case(8, 2, 1, one, ones, cond_bcs);
  branch_case(9, 1, 2, ones, one, cond_bns);
  branch_case(10, 1, 2, ones, one, cond_bnc);
  branch_case(11, 2, 1, one, ones, cond_bzc);
  branch_case(12, 2, 2, one, one, cond_bos);
  emit(hlt_word);
  run_program("carry_branch");
  finish_test("carry_branch");
endtask

task automatic memory_access_test;
  preset_word(16'h013e, 16'h1357);
  preset_word(16'h0145, 16'h8001);
  emit(imm_instr(sub_ldhz, 5, 8'h01));
  load_constant(4, 16'h0140);
  emit(mem_instr(GRP_LOAD, 1, 4, -2));
  emit(mem_instr(GRP_STORE, 1, 5, 0));
  expect_slot(0, 16'h1357);
  // Negative word sets N and BNS skips the second marker
  emit(imm_instr(sub_ldlz, 3, 8'h11));
  emit(mem_instr(GRP_LOAD, 2, 4, 5));
  emit(branch_instr(cond_bns, 1));
  emit(imm_instr(sub_ldlz, 3, 8'hee));
  emit(mem_instr(GRP_STORE, 3, 5, 1));
  expect_slot(1, 16'h0011);
  emit(mem_instr(GRP_STORE, 2, 5, 2));
  expect_slot(2, 16'h8001);
  emit(mem_instr(GRP_STORE, 1, 4, -8));
  expect_word(16'h0138, 16'h1357);
  emit(mem_instr(GRP_STORE, 2, 4, 16));
  expect_word(16'h0150, 16'h8001);
  emit(imm_instr(sub_ldlz, 1, 8'h00));
  emit(mem_instr(GRP_LOAD, 1, 4, -8));
  emit(mem_instr(GRP_STORE, 1, 5, 3));
  expect_slot(3, 16'h1357);
  emit(hlt_word);
  run_program("memory_access");
  finish_test("memory_access");
endtask

task automatic jump_halt_test;
  int loop_count;
  loop_count = 5;
  emit(imm_instr(sub_ldhz, 5, 8'h01));
  emit(imm_instr(sub_ldlz, 1, 8'h77));
  emit(jump_instr(2));
  emit(imm_instr(sub_ldlz, 1, 8'hbd));
  emit(mem_instr(GRP_STORE, 1, 5, 1));
  emit(mem_instr(GRP_STORE, 1, 5, 0));
  expect_slot(0, 16'h0077);
  expect_word(16'h0101, fill_value(16'h0101));
  emit(imm_instr(sub_ldlz, 2, loop_count[7:0]));
  emit(imm_instr(sub_ldlz, 3, 8'h00));
  // Loop body starts at word 8 and the branch back sits at word 10
  emit(reg_instr(fn_inc, 3, 3, 0));
  emit(reg_instr(fn_dec, 2, 2, 0));
  emit(branch_instr(cond_bzc, -3));
  emit(mem_instr(GRP_STORE, 3, 5, 2));
  emit(mem_instr(GRP_STORE, 2, 5, 3));
  expect_slot(2, word_t'(loop_count));
  expect_slot(3, 16'h0000);
  emit(hlt_word);
  emit(mem_instr(GRP_STORE, 1, 5, 4));
  expect_word(16'h0104, fill_value(16'h0104));
  run_program("jump_halt");
  repeat (20)
  begin
    @(negedge clk);
    if (mem.write !== 1'b0)
    begin
      $display("FAIL jump_halt: a memory write appeared after halt");
      test_errors++;
    end
  end
  finish_test("jump_halt");
endtask

task automatic random_arith_test;
  word_t a;
  word_t b;
  int    value;
  emit(imm_instr(sub_ldhz, 5, 8'h01));
  for (int i = 0; i < 10; i++)
  begin
    value = $random(seed);
    a = value[15:0];
    value = $random(seed);
    b = value[15:0];
    load_constant(1, a);
    load_constant(2, b);
    alu_case(fn_add, 1, 2, 3 * i, a + b);
    alu_case(fn_sub, 1, 2, 3 * i + 1, a - b);
    alu_case(fn_xor, 1, 2, 3 * i + 2, a ^ b);
  end
  emit(hlt_word);
  run_program("random_arith");
  finish_test("random_arith");
endtask

// File: verif/k16_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module k16_cpu_tb;
  import k16_arch_pkg::*;
  import k16_bus_pkg::*;

  localparam logic [3:0] fn_add = 4'b0000;
  localparam logic [3:0] fn_adc = 4'b0001;
  localparam logic [3:0] fn_sub = 4'b0010;
  localparam logic [3:0] fn_sbc = 4'b0011;
  localparam logic [3:0] fn_and = 4'b0100;
  localparam logic [3:0] fn_or  = 4'b0101;
  localparam logic [3:0] fn_xor = 4'b0110;
  localparam logic [3:0] fn_not = 4'b0111;
  localparam logic [3:0] fn_inc = 4'b1100;
  localparam logic [3:0] fn_cmp = 4'b1110;
  localparam logic [3:0] fn_dec = 4'b1111;

  localparam logic [1:0] sub_ldl  = 2'd0;
  localparam logic [1:0] sub_ldh  = 2'd1;
  localparam logic [1:0] sub_ldlz = 2'd2;
  localparam logic [1:0] sub_ldhz = 2'd3;

  localparam int cond_bcs = 0;
  localparam int cond_bcc = 1;
  localparam int cond_bzs = 2;
  localparam int cond_bzc = 3;
  localparam int cond_bns = 4;
  localparam int cond_bnc = 5;
  localparam int cond_bos = 6;

  localparam word_t clc_word  = {GRP_MISC, 9'd0, 4'b1000};
  localparam word_t sec_word  = {GRP_MISC, 9'd0, 4'b1001};
  localparam word_t hlt_word  = 16'h9fff;
  // Result slot base that every program keeps in r5
  localparam word_t data_base = 16'h0100;

  logic     clk;
  logic     reset;
  mem_req_t mem;
  word_t    data_in;
  logic     halted;

  word_t  memory [0:4095];
  word_t  code [$];
  word_t  preset_addr [$];
  word_t  preset_data [$];
  word_t  expect_addr [$];
  word_t  expect_data [$];
  int     cycle_budget = 2000;
  int     watchdog_cycles = 0;
  int     test_errors = 0;
  int     passed_tests = 0;
  int     failed_tests = 0;
  integer seed;

  k16_cpu k16_cpu_i (
    .clk     (clk),
    .reset   (reset),
    .mem     (mem),
    .data_in (data_in),
    .halted  (halted)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reads are asynchronous and writes happen on the rising edge
  assign data_in = memory[mem.address[11:0]];

  always @(posedge clk)
  begin
    if (mem.write === 1'b1)
    begin
      memory[mem.address[11:0]] <= mem.wdata;
    end
  end

  function automatic word_t fill_value(input int address);
    return {address[11:0], 4'h0} ^ 16'h6b3d;
  endfunction

  function automatic word_t reg_instr(input logic [3:0] func, input int d, input int s1,
                                      input int s2);
    return {GRP_REG, d[2:0], s1[2:0], s2[2:0], func};
  endfunction

  function automatic word_t imm_instr(input logic [1:0] sub2, input int d,
                                      input logic [7:0] imm);
    return {GRP_IMM, d[2:0], sub2, imm};
  endfunction

  function automatic word_t mem_instr(input logic [2:0] grp, input int d, input int base,
                                      input int off);
    return {grp, d[2:0], base[2:0], off[6:0]};
  endfunction

  // Branches and jumps are relative to the next instruction
  function automatic word_t branch_instr(input int cond, input int off);
    return {GRP_BRANCH, cond[2:0], 3'd7, off[6:0]};
  endfunction

  function automatic word_t jump_instr(input int off);
    return {GRP_JUMP, 3'd7, off[9:0]};
  endfunction

  task automatic emit(input word_t word);
    code.push_back(word);
  endtask

  task automatic preset_word(input word_t address, input word_t value);
    preset_addr.push_back(address);
    preset_data.push_back(value);
  endtask

  task automatic expect_word(input word_t address, input word_t value);
    expect_addr.push_back(address);
    expect_data.push_back(value);
  endtask

  task automatic expect_slot(input int slot, input word_t value);
    expect_word(word_t'(data_base + slot), value);
  endtask

  task automatic load_constant(input int d, input word_t value);
    emit(imm_instr(sub_ldlz, d, value[7:0]));
    emit(imm_instr(sub_ldh, d, value[15:8]));
  endtask

  // One ALU operation into r3 and a store of r3 at the given slot
  task automatic alu_case(input logic [3:0] func, input int s1, input int s2, input int slot,
                          input word_t expected);
    emit(reg_instr(func, 3, s1, s2));
    emit(mem_instr(GRP_STORE, 3, 5, slot));
    expect_slot(slot, expected);
  endtask

  // Marker 0x11 survives a taken branch and 0xee replaces it otherwise
  task automatic branch_case(input int slot, input int ra, input int rb, input word_t va,
                             input word_t vb, input int cond);
    logic [16:0] diff;
    logic        taken;
    diff = {1'b0, va} - {1'b0, vb};
    case (cond)
      cond_bcs: taken = diff[16];
      cond_bcc: taken = !diff[16];
      cond_bzs: taken = (diff[15:0] == 16'd0);
      cond_bzc: taken = (diff[15:0] != 16'd0);
      cond_bns: taken = diff[15];
      cond_bnc: taken = !diff[15];
      default:  taken = 1'b0;
    endcase
    emit(imm_instr(sub_ldlz, 4, 8'h11));
    emit(reg_instr(fn_cmp, 0, ra, rb));
    emit(branch_instr(cond, 1));
    emit(imm_instr(sub_ldlz, 4, 8'hee));
    emit(mem_instr(GRP_STORE, 4, 5, slot));
    expect_slot(slot, taken ? 16'h0011 : 16'h00ee);
  endtask

  task automatic pulse_reset(input string name);
    @(posedge clk);
    reset <= 1'b1;
    repeat (4)
    begin
      @(posedge clk);
      @(negedge clk);
      if (mem.write !== 1'b0 || halted !== 1'b0)
      begin
        $display("FAIL %s: write or halted is not low during reset", name);
        test_errors++;
      end
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (mem.address !== 16'h0000)
    begin
      $display("FAIL %s: first fetch address expected %h actual %h", name,
               16'h0000, mem.address);
      test_errors++;
    end
    if (mem.write !== 1'b0 || halted !== 1'b0)
    begin
      $display("FAIL %s: write or halted is not low after reset", name);
      test_errors++;
    end
  endtask

  task automatic run_program(input string name);
    for (int i = 0; i < 4096; i++)
    begin
      memory[i] <= fill_value(i);
    end
    foreach (code[i])
    begin
      memory[i] <= code[i];
    end
    foreach (preset_addr[i])
    begin
      memory[preset_addr[i][11:0]] <= preset_data[i];
    end
    cycle_budget += code.size() * 6;
    pulse_reset(name);
    do
      @(negedge clk);
    while (halted !== 1'b1);
  endtask

  task automatic finish_test(input string name);
    word_t actual;
    foreach (expect_addr[i])
    begin
      actual = memory[expect_addr[i][11:0]];
      if (actual !== expect_data[i])
      begin
        $display("FAIL %s: mem[%h] expected %h actual %h", name, expect_addr[i],
                 expect_data[i], actual);
        test_errors++;
      end
    end
    if (test_errors == 0)
    begin
      passed_tests++;
      $display("%s: passed", name);
    end
    else
    begin
      failed_tests++;
      $display("%s: failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
    code.delete();
    preset_addr.delete();
    preset_data.delete();
    expect_addr.delete();
    expect_data.delete();
  endtask

  `include "k16_cpu_tests.svh"

  // Budget grows by six cycles per program word as each test loads
  initial
  begin
    while (watchdog_cycles <= cycle_budget)
    begin
      @(posedge clk);
      watchdog_cycles++;
    end
    $display("Timeout: the CPU did not halt within %0d cycles", cycle_budget);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    reset <= 1'b1;
    seed = 32'hf4e36ca0;
    reset_state_test();
    alu_test();
    carry_branch_test();
    memory_access_test();
    jump_halt_test();
    random_arith_test();
    $display("Summary: %0d tests passed, %0d tests failed", passed_tests, failed_tests);
    if (failed_tests == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
